// File: include/nlb_config.svh
// NLB configuration
// Datapath widths, copy buffer depth, CSR byte offsets and mode codes
`ifndef NLB_CONFIG_SVH
`define NLB_CONFIG_SVH

// Memory port widths
`define NLB_ADDR_W 42
`define NLB_DATA_W 512
// Transaction ID carries the line index
`define NLB_TID_W 16

// MMIO port widths
`define NLB_CSR_ADDR_W 16
`define NLB_CSR_DATA_W 64

// Copy buffer entries, power of two
`define NLB_FIFO_DEPTH 8

// --------------------------------------------------
// CSR byte offsets
// --------------------------------------------------
`define NLB_CSR_SCRATCH 16'h0100
`define NLB_CSR_SRC 16'h0120
`define NLB_CSR_DST 16'h0128
`define NLB_CSR_NUM_LINES 16'h0130
`define NLB_CSR_CTL 16'h0138
`define NLB_CSR_CFG 16'h0140
`define NLB_CSR_STATUS 16'h0160
`define NLB_CSR_NUM_READS 16'h0168
`define NLB_CSR_NUM_WRITES 16'h0170

// Test modes as held in CFG bits 4 to 2
`define NLB_M_LPBK1 3'd0
`define NLB_M_READ 3'd1
`define NLB_M_WRITE 3'd2

`endif

// File: design/nlb_pkg.sv
// NLB shared types
// Width typedefs, the bundled test configuration and status,
// memory request fields and the FSM enums
`include "nlb_config.svh"

package nlb_pkg;

  // Plain vectors with a meaning
  typedef logic [`NLB_ADDR_W-1:0] line_addr_t;
  typedef logic [`NLB_DATA_W-1:0] line_data_t;
  typedef logic [`NLB_TID_W-1:0] tid_t;
  typedef logic [31:0] count_t;
  typedef logic [`NLB_CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`NLB_CSR_DATA_W-1:0] csr_data_t;

  // Test mode, same encoding as CFG[4:2]
  typedef enum logic [2:0]
  {
    LPBK1 = `NLB_M_LPBK1,
    READ = `NLB_M_READ,
    WRITE = `NLB_M_WRITE
  } test_mode_e;

  // Test engine FSM
  typedef enum logic [1:0]
  {
    IDLE,
    RUN,
    DONE
  } engine_state_e;

  // --------------------------------------------------
  // Bundles
  // --------------------------------------------------
  // Configuration seen by the engine and requestor
  typedef struct packed {
    line_addr_t src_addr;
    line_addr_t dst_addr;
    count_t num_lines;
    test_mode_e mode;
  } test_cfg_t;

  // One read or write request header
  typedef struct packed {
    line_addr_t addr;
    tid_t tid;
  } mem_req_t;

  // Results returned to the CSR block
  typedef struct packed {
    logic done;
    count_t num_reads;
    count_t num_writes;
  } test_status_t;

endpackage

// File: design/nlb_csr.sv
// NLB CSR block
// Decodes MMIO writes into the scratchpad and test registers,
// turns CTL writes into start and force pulses and returns
// registered read data one cycle after each read strobe
`include "nlb_config.svh"

module nlb_csr
(
  input  logic                  Clk_400,
  input  logic                  rst,
  input  logic                  mmio_wr,
  input  logic                  mmio_rd,
  input  nlb_pkg::csr_addr_t    mmio_addr,
  input  nlb_pkg::csr_data_t    mmio_wdata,
  input  nlb_pkg::test_status_t status,
  input  logic                  busy,
  output nlb_pkg::csr_data_t    mmio_rdata,
  output logic                  mmio_rvalid,
  output nlb_pkg::test_cfg_t    cfg,
  output logic                  go,
  output logic                  force_cmp,
  output logic                  test_rst
);

  nlb_pkg::csr_data_t scratch;
  // CTL bits, {force, start, reset_n}
  logic [2:0] ctl;
  logic ctl_wr;
  logic cfg_wr;

  assign ctl_wr = mmio_wr && (mmio_addr == `NLB_CSR_CTL);
  // Test setup is frozen once the engine leaves idle
  assign cfg_wr = mmio_wr && !busy;

  // Test held in reset until software sets CTL bit 0
  assign test_rst = !ctl[0];

  // --------------------------------------------------
  // Register writes
  // --------------------------------------------------
  always_ff @(posedge Clk_400)
  begin
    if (rst)
    begin
      scratch <= '0;
      ctl <= '0;
      cfg <= '0;
    end
    else
    begin
      // Scratchpad always writable
      if (mmio_wr && (mmio_addr == `NLB_CSR_SCRATCH))
        scratch <= mmio_wdata;
      if (ctl_wr)
        ctl <= mmio_wdata[2:0];
      if (cfg_wr)
      begin
        case (mmio_addr)
          `NLB_CSR_SRC:
            cfg.src_addr <= mmio_wdata[`NLB_ADDR_W-1:0];
          `NLB_CSR_DST:
            cfg.dst_addr <= mmio_wdata[`NLB_ADDR_W-1:0];
          `NLB_CSR_NUM_LINES:
            cfg.num_lines <= mmio_wdata[31:0];
          // Mode field lives in bits 4 to 2
          `NLB_CSR_CFG:
            cfg.mode <= nlb_pkg::test_mode_e'(mmio_wdata[4:2]);
          default:
            ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Control pulses and read strobe
  // --------------------------------------------------
  always_ff @(posedge Clk_400)
  begin
    if (rst)
    begin
      go <= 1'b0;
      force_cmp <= 1'b0;
      mmio_rvalid <= 1'b0;
    end
    else
    begin
      // Start only honoured from idle
      go <= ctl_wr && mmio_wdata[1] && !busy;
      force_cmp <= ctl_wr && mmio_wdata[2];
      mmio_rvalid <= mmio_rd;
    end
  end

  // Read mux, captured with the strobe
  always_ff @(posedge Clk_400)
  begin
    if (mmio_rd)
    begin
      case (mmio_addr)
        `NLB_CSR_SCRATCH:
          mmio_rdata <= scratch;
        `NLB_CSR_SRC:
          mmio_rdata <= nlb_pkg::csr_data_t'(cfg.src_addr);
        `NLB_CSR_DST:
          mmio_rdata <= nlb_pkg::csr_data_t'(cfg.dst_addr);
        `NLB_CSR_NUM_LINES:
          mmio_rdata <= nlb_pkg::csr_data_t'(cfg.num_lines);
        `NLB_CSR_CTL:
          mmio_rdata <= nlb_pkg::csr_data_t'(ctl);
        `NLB_CSR_CFG:
          mmio_rdata <= nlb_pkg::csr_data_t'({cfg.mode, 2'b00});
        // Done flag in bit 0
        `NLB_CSR_STATUS:
          mmio_rdata <= nlb_pkg::csr_data_t'(status.done);
        `NLB_CSR_NUM_READS:
          mmio_rdata <= nlb_pkg::csr_data_t'(status.num_reads);
        `NLB_CSR_NUM_WRITES:
          mmio_rdata <= nlb_pkg::csr_data_t'(status.num_writes);
        // Holes read as zero
        default:
          mmio_rdata <= '0;
      endcase
    end
  end

endmodule

// File: design/nlb_test_engine.sv
// NLB test engine
// Test FSM, read issue from the source buffer, read response
// counting and the per-mode completion decision
`include "nlb_config.svh"

module nlb_test_engine
(
  input  logic                              Clk_400,
  input  logic                              rst,
  input  logic                              test_rst,
  input  nlb_pkg::test_cfg_t                cfg,
  input  logic                              go,
  input  logic                              force_cmp,
  input  logic                              rd_almfull,
  input  logic                              rd_rsp_valid,
  input  nlb_pkg::tid_t                     rd_rsp_tid,
  input  logic [$clog2(`NLB_FIFO_DEPTH):0]  fifo_count,
  input  nlb_pkg::count_t                   wr_count,
  input  nlb_pkg::count_t                   wr_rsp_count,
  output nlb_pkg::mem_req_t                 rd_req,
  output logic                              rd_req_valid,
  output logic                              fifo_push,
  output logic                              write_go,
  output logic                              busy,
  output nlb_pkg::test_status_t             status
);

  nlb_pkg::engine_state_e state;
  nlb_pkg::engine_state_e state_nxt;
  // Reads issued, doubles as next line index
  nlb_pkg::count_t rd_idx;
  nlb_pkg::count_t rd_rsp_cnt;
  nlb_pkg::count_t in_flight;
  logic reads_on;
  logic buf_room;
  logic rsp_take;
  logic all_done;

  // --------------------------------------------------
  // Read issue
  // --------------------------------------------------
  assign reads_on = (cfg.mode == nlb_pkg::READ) || (cfg.mode == nlb_pkg::LPBK1);

  // Outstanding reads plus lines parked in the copy buffer
  assign in_flight = (rd_idx - rd_rsp_cnt) + nlb_pkg::count_t'(fifo_count);
  // Copy buffer can never overflow in LPBK1
  assign buf_room = (cfg.mode != nlb_pkg::LPBK1) || (in_flight < `NLB_FIFO_DEPTH);

  // Combinational so almost-full blocks the same cycle
  assign rd_req_valid = (state == nlb_pkg::RUN) && reads_on && buf_room
                      && (rd_idx < cfg.num_lines) && !rd_almfull;
  assign rd_req.addr = cfg.src_addr + nlb_pkg::line_addr_t'(rd_idx);
  assign rd_req.tid = nlb_pkg::tid_t'(rd_idx);

  // Responses
  // Tags past the line count are stray and dropped
  assign rsp_take = rd_rsp_valid && (state == nlb_pkg::RUN)
                  && (nlb_pkg::count_t'(rd_rsp_tid) < cfg.num_lines);
  assign fifo_push = rsp_take && (cfg.mode == nlb_pkg::LPBK1);

  // READ ends on reads, WRITE and LPBK1 on write responses
  assign all_done = (cfg.mode == nlb_pkg::READ) ? (rd_rsp_cnt == cfg.num_lines)
                                                : (wr_rsp_count == cfg.num_lines);

  // --------------------------------------------------
  // Test FSM
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      nlb_pkg::IDLE:
        if (go)
          state_nxt = nlb_pkg::RUN;
      nlb_pkg::RUN:
        if (all_done || force_cmp)
          state_nxt = nlb_pkg::DONE;
      // DONE holds until the test reset
      default:
        state_nxt = nlb_pkg::DONE;
    endcase
  end

  // Counters only clear through the test reset
  always_ff @(posedge Clk_400)
  begin
    if (rst || test_rst)
    begin
      state <= nlb_pkg::IDLE;
      rd_idx <= '0;
      rd_rsp_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (rd_req_valid)
        rd_idx <= rd_idx + 1'b1;
      if (rsp_take)
        rd_rsp_cnt <= rd_rsp_cnt + 1'b1;
    end
  end

  // Write side runs only in RUN and never in READ
  assign write_go = (state == nlb_pkg::RUN) && (cfg.mode != nlb_pkg::READ);
  assign busy = (state != nlb_pkg::IDLE);

  assign status.done = (state == nlb_pkg::DONE);
  assign status.num_reads = rd_rsp_cnt;
  assign status.num_writes = wr_count;

endmodule

// File: design/nlb_line_fifo.sv
// NLB copy buffer
// Circular buffer of read lines with their line index, feeding
// the write side in LPBK1 and flushed by the test reset
`include "nlb_config.svh"

module nlb_line_fifo
(
  input  logic                              Clk_400,
  input  logic                              rst,
  input  logic                              test_rst,
  input  logic                              push,
  input  nlb_pkg::tid_t                     push_tid,
  input  nlb_pkg::line_data_t               push_data,
  input  logic                              pop,
  output logic                              not_empty,
  output nlb_pkg::tid_t                     head_tid,
  output nlb_pkg::line_data_t               head_data,
  output logic [$clog2(`NLB_FIFO_DEPTH):0]  count
);

  localparam int PTR_W = $clog2(`NLB_FIFO_DEPTH);

  nlb_pkg::line_data_t data_mem [`NLB_FIFO_DEPTH];
  nlb_pkg::tid_t tid_mem [`NLB_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // Storage
  always_ff @(posedge Clk_400)
  begin
    if (push)
    begin
      data_mem[wr_ptr] <= push_data;
      tid_mem[wr_ptr] <= push_tid;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge Clk_400)
  begin
    if (rst || test_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          ;
      endcase
    end
  end

  // Head visible the cycle after its push
  assign not_empty = (count != '0);
  assign head_tid = tid_mem[rd_ptr];
  assign head_data = data_mem[rd_ptr];

endmodule

// File: design/nlb_requestor.sv
// NLB write requestor
// Builds write requests from generated lines or the copy buffer,
// holds off on write almost-full and counts writes and responses
`include "nlb_config.svh"

module nlb_requestor
(
  input  logic                Clk_400,
  input  logic                rst,
  input  logic                test_rst,
  input  nlb_pkg::test_cfg_t  cfg,
  input  logic                write_go,
  input  logic                wr_almfull,
  input  logic                wr_rsp_valid,
  input  logic                fifo_not_empty,
  input  nlb_pkg::tid_t       fifo_tid,
  input  nlb_pkg::line_data_t fifo_data,
  output logic                fifo_pop,
  output nlb_pkg::mem_req_t   wr_req,
  output logic                wr_req_valid,
  output nlb_pkg::line_data_t wr_data,
  output nlb_pkg::count_t     wr_count,
  output nlb_pkg::count_t     wr_rsp_count
);

  // 32-bit words per line
  localparam int WORDS = `NLB_DATA_W / 32;

  logic gen_mode;
  logic copy_mode;
  nlb_pkg::count_t line_idx;

  assign gen_mode = write_go && (cfg.mode == nlb_pkg::WRITE);
  assign copy_mode = write_go && (cfg.mode == nlb_pkg::LPBK1);

  // WRITE goes in order, so the sent count is the next index
  assign line_idx = copy_mode ? nlb_pkg::count_t'(fifo_tid) : wr_count;

  // --------------------------------------------------
  // Request forming
  // --------------------------------------------------
  assign fifo_pop = copy_mode && fifo_not_empty && !wr_almfull;
  assign wr_req_valid = fifo_pop
                      || (gen_mode && (wr_count < cfg.num_lines) && !wr_almfull);

  assign wr_req.addr = cfg.dst_addr + nlb_pkg::line_addr_t'(line_idx);
  assign wr_req.tid = nlb_pkg::tid_t'(line_idx);
  // Pattern is the line index in every word
  assign wr_data = copy_mode ? fifo_data : {WORDS{wr_count}};

  // Write and response counters
  always_ff @(posedge Clk_400)
  begin
    if (rst || test_rst)
    begin
      wr_count <= '0;
      wr_rsp_count <= '0;
    end
    else
    begin
      if (wr_req_valid)
        wr_count <= wr_count + 1'b1;
      if (wr_rsp_valid)
        wr_rsp_count <= wr_rsp_count + 1'b1;
    end
  end

endmodule

// File: design/nlb_lpbk.sv
// NLB loopback top
// CSR block, test engine, copy buffer and write requestor
// between the MMIO port and the memory request ports
`include "nlb_config.svh"

module nlb_lpbk
(
  input  logic                Clk_400,
  input  logic                rst,
  // MMIO
  input  logic                mmio_wr,
  input  logic                mmio_rd,
  input  nlb_pkg::csr_addr_t  mmio_addr,
  input  nlb_pkg::csr_data_t  mmio_wdata,
  output nlb_pkg::csr_data_t  mmio_rdata,
  output logic                mmio_rvalid,
  // Memory read port
  output logic                rd_req_valid,
  output nlb_pkg::mem_req_t   rd_req,
  input  logic                rd_almfull,
  input  logic                rd_rsp_valid,
  input  nlb_pkg::tid_t       rd_rsp_tid,
  input  nlb_pkg::line_data_t rd_rsp_data,
  // Memory write port
  output logic                wr_req_valid,
  output nlb_pkg::mem_req_t   wr_req,
  output nlb_pkg::line_data_t wr_data,
  input  logic                wr_almfull,
  input  logic                wr_rsp_valid
);

  // CSR to engine
  nlb_pkg::test_cfg_t cfg;
  nlb_pkg::test_status_t status;
  logic go;
  logic force_cmp;
  logic test_rst;
  logic busy;

  // Copy buffer and write side
  logic fifo_push;
  logic fifo_pop;
  logic fifo_not_empty;
  nlb_pkg::tid_t fifo_tid;
  nlb_pkg::line_data_t fifo_data;
  logic [$clog2(`NLB_FIFO_DEPTH):0] fifo_count;
  logic write_go;
  nlb_pkg::count_t wr_count;
  nlb_pkg::count_t wr_rsp_count;

  nlb_csr nlb_csr_inst
  (
    .Clk_400(Clk_400),
    .rst(rst),
    .mmio_wr(mmio_wr),
    .mmio_rd(mmio_rd),
    .mmio_addr(mmio_addr),
    .mmio_wdata(mmio_wdata),
    .status(status),
    .busy(busy),
    .mmio_rdata(mmio_rdata),
    .mmio_rvalid(mmio_rvalid),
    .cfg(cfg),
    .go(go),
    .force_cmp(force_cmp),
    .test_rst(test_rst)
  );

  nlb_test_engine nlb_test_engine_inst
  (
    .Clk_400(Clk_400),
    .rst(rst),
    .test_rst(test_rst),
    .cfg(cfg),
    .go(go),
    .force_cmp(force_cmp),
    .rd_almfull(rd_almfull),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_tid(rd_rsp_tid),
    .fifo_count(fifo_count),
    .wr_count(wr_count),
    .wr_rsp_count(wr_rsp_count),
    .rd_req(rd_req),
    .rd_req_valid(rd_req_valid),
    .fifo_push(fifo_push),
    .write_go(write_go),
    .busy(busy),
    .status(status)
  );

  // Read data is tagged with its response ID
  nlb_line_fifo nlb_line_fifo_inst
  (
    .Clk_400(Clk_400),
    .rst(rst),
    .test_rst(test_rst),
    .push(fifo_push),
    .push_tid(rd_rsp_tid),
    .push_data(rd_rsp_data),
    .pop(fifo_pop),
    .not_empty(fifo_not_empty),
    .head_tid(fifo_tid),
    .head_data(fifo_data),
    .count(fifo_count)
  );

  nlb_requestor nlb_requestor_inst
  (
    .Clk_400(Clk_400),
    .rst(rst),
    .test_rst(test_rst),
    .cfg(cfg),
    .write_go(write_go),
    .wr_almfull(wr_almfull),
    .wr_rsp_valid(wr_rsp_valid),
    .fifo_not_empty(fifo_not_empty),
    .fifo_tid(fifo_tid),
    .fifo_data(fifo_data),
    .fifo_pop(fifo_pop),
    .wr_req(wr_req),
    .wr_req_valid(wr_req_valid),
    .wr_data(wr_data),
    .wr_count(wr_count),
    .wr_rsp_count(wr_rsp_count)
  );

endmodule

// File: bench/nlb_lpbk_chk.sv
// NLB loopback protocol checks
// Almost-full compliance, MMIO read latency and quiet outputs in reset
module nlb_lpbk_chk
(
  input logic Clk_400,
  input logic rst,
  input logic mmio_rd,
  input logic mmio_rvalid,
  input logic rd_req_valid,
  input logic rd_almfull,
  input logic wr_req_valid,
  input logic wr_almfull
);

  // Failed assertions, summed into the final report
  int fails = 0;

  // No request while its almost-full level is high
  rd_af_hold: assert property (@(posedge Clk_400) disable iff (rst)
    rd_req_valid |-> !rd_almfull)
  else
  begin
    $error("read request issued under read almost-full");
    fails++;
  end

  wr_af_hold: assert property (@(posedge Clk_400) disable iff (rst)
    wr_req_valid |-> !wr_almfull)
  else
  begin
    $error("write request issued under write almost-full");
    fails++;
  end

  // Read data follows the strobe by one cycle and never comes alone
  rvalid_after_rd: assert property (@(posedge Clk_400) disable iff (rst)
    mmio_rd |=> mmio_rvalid)
  else
  begin
    $error("mmio_rvalid missing one cycle after mmio_rd");
    fails++;
  end

  rvalid_needs_rd: assert property (@(posedge Clk_400) disable iff (rst)
    mmio_rvalid |-> $past(mmio_rd))
  else
  begin
    $error("mmio_rvalid without mmio_rd one cycle before");
    fails++;
  end

  // From the second reset cycle on all valids stay low
  quiet_in_reset: assert property (@(posedge Clk_400)
    rst && $past(rst) |-> !rd_req_valid && !wr_req_valid && !mmio_rvalid)
  else
  begin
    $error("valid output active during reset");
    fails++;
  end

endmodule

bind nlb_lpbk nlb_lpbk_chk nlb_lpbk_chk_inst
(
  .Clk_400(Clk_400),
  .rst(rst),
  .mmio_rd(mmio_rd),
  .mmio_rvalid(mmio_rvalid),
  .rd_req_valid(rd_req_valid),
  .rd_almfull(rd_almfull),
  .wr_req_valid(wr_req_valid),
  .wr_almfull(wr_almfull)
);

// File: bench/nlb_lpbk_tb.sv
// NLB loopback testbench
// MMIO driver and a memory model with random almost-full levels
// and out-of-order read responses, checking every request
`include "nlb_config.svh"

module nlb_lpbk_tb;

  // Cycles or polls allowed for any single wait
  localparam int TIMEOUT = 2000;

  logic Clk_400;
  logic rst;
  logic mmio_wr;
  logic mmio_rd;
  nlb_pkg::csr_addr_t mmio_addr;
  nlb_pkg::csr_data_t mmio_wdata;
  nlb_pkg::csr_data_t mmio_rdata;
  logic mmio_rvalid;
  logic rd_req_valid;
  nlb_pkg::mem_req_t rd_req;
  logic rd_almfull;
  logic rd_rsp_valid;
  nlb_pkg::tid_t rd_rsp_tid;
  nlb_pkg::line_data_t rd_rsp_data;
  logic wr_req_valid;
  nlb_pkg::mem_req_t wr_req;
  nlb_pkg::line_data_t wr_data;
  logic wr_almfull;
  logic wr_rsp_valid;

  // Current test setup for the compare process
  logic [2:0] exp_mode;
  nlb_pkg::line_addr_t exp_src;
  nlb_pkg::line_addr_t exp_dst;
  int exp_n;
  // Request counts and their snapshot at each start
  int rd_issued = 0;
  int wr_issued = 0;
  int rd_base;
  int wr_base;
  // Write log keyed by line address
  bit line_seen [nlb_pkg::line_addr_t];
  // Source lines already read
  bit read_seen [nlb_pkg::line_addr_t];
  int errors = 0;
  int timeouts = 0;
  logic [31:0] lfsr;
  // Reads waiting for their response
  int rd_pend_tid [$];
  nlb_pkg::line_addr_t rd_pend_addr [$];
  int rd_pend_wait [$];
  int wr_pend;

  nlb_lpbk nlb_lpbk_inst (.*);

  initial
  begin
    Clk_400 = 1'b0;
    forever #20 Clk_400 = ~Clk_400;
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] r;
    logic fb;
    int i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Source buffer contents mix the whole line address into every word
  function automatic nlb_pkg::line_data_t src_line(input nlb_pkg::line_addr_t addr);
    nlb_pkg::line_data_t d;
    int w;
    for (w = 0; w < `NLB_DATA_W / 32; w++)
      d[w*32 +: 32] = addr[31:0] ^ (32'(addr >> 32) << 22) ^ (32'(w) * 32'h0101_0101);
    return d;
  endfunction

  // Reference for destination line idx
  function automatic nlb_pkg::line_data_t expected_line(input logic [2:0] mode,
                                                        input nlb_pkg::line_addr_t src,
                                                        input int idx);
    if (mode == `NLB_M_WRITE)
      return {(`NLB_DATA_W / 32){32'(idx)}};
    return src_line(src + nlb_pkg::line_addr_t'(idx));
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR @%0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Gave up waiting for %s at time %0t", what, $time);
  endtask

  // --------------------------------------------------
  // MMIO driver
  // --------------------------------------------------
  task automatic csr_write(input nlb_pkg::csr_addr_t addr, input nlb_pkg::csr_data_t data);
    @(posedge Clk_400);
    mmio_wr <= 1'b1;
    mmio_addr <= addr;
    mmio_wdata <= data;
    @(posedge Clk_400);
    mmio_wr <= 1'b0;
  endtask

  // Data is due exactly one cycle after the strobe
  task automatic csr_read(input nlb_pkg::csr_addr_t addr, output nlb_pkg::csr_data_t data);
    int n;
    @(posedge Clk_400);
    mmio_rd <= 1'b1;
    mmio_addr <= addr;
    @(posedge Clk_400);
    mmio_rd <= 1'b0;
    n = 0;
    do
    begin
      @(posedge Clk_400);
      n++;
    end
    while (!mmio_rvalid && n < TIMEOUT);
    data = mmio_rdata;
    if (!mmio_rvalid)
      report_timeout("MMIO read data");
    else if (n != 1)
      report_error($sformatf("read of 0x%0h answered after %0d cycles", addr, n));
  endtask

  task automatic check_csr(input nlb_pkg::csr_addr_t addr, input nlb_pkg::csr_data_t exp);
    nlb_pkg::csr_data_t d;
    csr_read(addr, d);
    if (d !== exp)
      report_error($sformatf("CSR 0x%0h read 0x%0h, expected 0x%0h", addr, d, exp));
  endtask

  // Drain memory, reset the test, program it and start
  task automatic start_test(input logic [2:0] mode, input nlb_pkg::line_addr_t src,
                            input nlb_pkg::line_addr_t dst, input int n);
    int t;
    t = 0;
    while ((rd_pend_tid.size() != 0 || wr_pend != 0) && t < TIMEOUT)
    begin
      @(posedge Clk_400);
      t++;
    end
    if (t >= TIMEOUT)
      report_timeout("the memory model to drain");
    csr_write(`NLB_CSR_CTL, 64'd0);
    exp_mode = mode;
    exp_src = src;
    exp_dst = dst;
    exp_n = n;
    rd_base = rd_issued;
    wr_base = wr_issued;
    csr_write(`NLB_CSR_SRC, 64'(src));
    csr_write(`NLB_CSR_DST, 64'(dst));
    csr_write(`NLB_CSR_NUM_LINES, 64'(n));
    csr_write(`NLB_CSR_CFG, 64'(mode) << 2);
    // Release the test reset, then start
    csr_write(`NLB_CSR_CTL, 64'd1);
    csr_write(`NLB_CSR_CTL, 64'd3);
  endtask

  task automatic wait_done();
    nlb_pkg::csr_data_t d;
    int t;
    t = 0;
    d = '0;
    while (!d[0] && t < TIMEOUT)
    begin
      csr_read(`NLB_CSR_STATUS, d);
      t++;
    end
    if (!d[0])
      report_timeout("STATUS done");
  endtask

  task automatic check_traffic(input int reads, input int writes);
    if (rd_issued - rd_base != reads)
      report_error($sformatf("%0d reads issued, expected %0d", rd_issued - rd_base, reads));
    if (wr_issued - wr_base != writes)
      report_error($sformatf("%0d writes issued, expected %0d", wr_issued - wr_base, writes));
  endtask

  // --------------------------------------------------
  // Memory model
  // --------------------------------------------------
  initial
  begin
    int pick;
    int i;
    lfsr = 32'd32111;
    rd_almfull = 1'b0;
    wr_almfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_tid = '0;
    rd_rsp_data = '0;
    wr_rsp_valid = 1'b0;
    wr_pend = 0;
    forever
    begin
      @(posedge Clk_400);
      if (rst)
      begin
        rd_almfull <= 1'b0;
        wr_almfull <= 1'b0;
        rd_rsp_valid <= 1'b0;
        wr_rsp_valid <= 1'b0;
      end
      else
      begin
        // Almost-full high about one cycle in four
        rd_almfull <= (draw_bits(2) == 0);
        wr_almfull <= (draw_bits(2) == 0);
        // First entry whose delay ran out answers, so order gets shuffled
        pick = -1;
        for (i = 0; i < rd_pend_tid.size(); i++)
        begin
          if (rd_pend_wait[i] > 0)
            rd_pend_wait[i] = rd_pend_wait[i] - 1;
          else if (pick < 0)
            pick = i;
        end
        rd_rsp_valid <= (pick >= 0);
        if (pick >= 0)
        begin
          rd_rsp_tid <= nlb_pkg::tid_t'(rd_pend_tid[pick]);
          rd_rsp_data <= src_line(rd_pend_addr[pick]);
          rd_pend_tid.delete(pick);
          rd_pend_addr.delete(pick);
          rd_pend_wait.delete(pick);
        end
        if (rd_req_valid)
        begin
          rd_pend_tid.push_back(int'(rd_req.tid));
          rd_pend_addr.push_back(rd_req.addr);
          rd_pend_wait.push_back(int'(draw_bits(3)));
        end
        // Write responses trickle back at random
        wr_rsp_valid <= 1'b0;
        if (wr_pend > 0 && draw_bits(1) == 1)
        begin
          wr_rsp_valid <= 1'b1;
          wr_pend--;
        end
        if (wr_req_valid)
          wr_pend++;
      end
    end
  end

  // Compare process for every read and write request
  always @(posedge Clk_400)
  begin
    longint idx;
    if (!rst && rd_req_valid)
    begin
      rd_issued++;
      if (exp_mode == `NLB_M_WRITE || rd_req.tid >= exp_n
          || rd_req.addr != exp_src + nlb_pkg::line_addr_t'(rd_req.tid))
        report_error($sformatf("read tid %0d at 0x%0h is out of place", rd_req.tid, rd_req.addr));
      else if (read_seen.exists(rd_req.addr))
        report_error($sformatf("line 0x%0h read twice", rd_req.addr));
      read_seen[rd_req.addr] = 1'b1;
    end
    if (!rst && wr_req_valid)
    begin
      wr_issued++;
      idx = longint'(wr_req.addr - exp_dst);
      if (exp_mode == `NLB_M_READ || idx >= exp_n)
        report_error($sformatf("write at 0x%0h outside the destination", wr_req.addr));
      else if (line_seen.exists(wr_req.addr))
        report_error($sformatf("line 0x%0h written twice", wr_req.addr));
      else if (wr_req.tid != nlb_pkg::tid_t'(idx))
        report_error($sformatf("write to line %0d carries tid %0d", idx, wr_req.tid));
      else if (wr_data !== expected_line(exp_mode, exp_src, int'(idx)))
        report_error($sformatf("wrong data in destination line %0d", idx));
      line_seen[wr_req.addr] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    nlb_pkg::csr_data_t d;
    int total;
    rst = 1'b1;
    mmio_wr = 1'b0;
    mmio_rd = 1'b0;
    mmio_addr = '0;
    mmio_wdata = '0;
    repeat (2) @(posedge Clk_400);
    rst <= 1'b0;

    // Scratchpad round trip and a hole in the map
    csr_write(`NLB_CSR_SCRATCH, 64'hA5C3_0F1E_2D3C_4B5A);
    check_csr(`NLB_CSR_SCRATCH, 64'hA5C3_0F1E_2D3C_4B5A);
    check_csr(16'h0150, 64'd0);

    // READ touches the source only
    start_test(`NLB_M_READ, 42'h0_1000, 42'h0_9000, 12);
    wait_done();
    check_traffic(12, 0);
    check_csr(`NLB_CSR_STATUS, 64'd1);
    check_csr(`NLB_CSR_NUM_READS, 64'd12);

    // WRITE pattern lines
    start_test(`NLB_M_WRITE, 42'h0, 42'h2_0000, 20);
    wait_done();
    check_traffic(0, 20);
    check_csr(`NLB_CSR_STATUS, 64'd1);
    check_csr(`NLB_CSR_NUM_WRITES, 64'd20);

    // LPBK1 copy under back-pressure
    start_test(`NLB_M_LPBK1, 42'h3_0100, 42'h3_8000, 40);
    wait_done();
    check_traffic(40, 40);
    check_csr(`NLB_CSR_NUM_READS, 64'd40);
    check_csr(`NLB_CSR_NUM_WRITES, 64'd40);

    // Locked setup while running, then forced completion
    start_test(`NLB_M_LPBK1, 42'h4_0000, 42'h5_0000, 300);
    csr_write(`NLB_CSR_NUM_LINES, 64'd5);
    csr_write(`NLB_CSR_CFG, 64'(`NLB_M_READ) << 2);
    check_csr(`NLB_CSR_NUM_LINES, 64'd300);
    check_csr(`NLB_CSR_CFG, 64'(`NLB_M_LPBK1) << 2);
    csr_write(`NLB_CSR_CTL, 64'd5);
    wait_done();
    csr_read(`NLB_CSR_NUM_WRITES, d);
    if (d >= 64'd300)
      report_error($sformatf("forced test still wrote %0d lines", d));

    total = errors + timeouts + nlb_lpbk_inst.nlb_lpbk_chk_inst.fails;
    $display("Summary: %0d errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, nlb_lpbk_inst.nlb_lpbk_chk_inst.fails);
    if (total == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
design/nlb_pkg.sv
design/nlb_csr.sv
design/nlb_test_engine.sv
design/nlb_line_fifo.sv
design/nlb_requestor.sv
design/nlb_lpbk.sv
bench/nlb_lpbk_chk.sv
bench/nlb_lpbk_tb.sv

// File: Makefile
# Verilator build and run for the NLB loopback testbench

VERILATOR ?= verilator
TOP       ?= nlb_lpbk_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG) || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
